//--- hw/dsp_cfg_pkg.sv
// sizes and counts shared by the readout DSP blocks
// imported by every RTL module and by the testbench

package dsp_cfg_pkg;

	// one signed sample lane
	localparam int lane_w = 16;

	// lanes per converter word
	localparam int adc_lanes = 4;
	localparam int dac_lanes = 16;
	// dac lane stride when folding a dac word into adc format
	localparam int undersample_step = dac_lanes / adc_lanes;

	// converter and processor counts
	localparam int nadc = 2;
	localparam int ndac = 2;
	localparam int nproc = 4;

	// drive words summed into each dac output
	localparam int ndrv_group = 2;

	// readout channels, first ndlo1 run on baseband 0
	localparam int ndlo = 4;
	localparam int ndlo1 = 2;

	// accumulation buffer word halves and pointer
	localparam int acc_half_w = 32;
	localparam int acc_addr_w = 4;

	// control field widths
	localparam int shot_w = 32;
	localparam int shift_w = 5;
	localparam int bb_sel_w = 2;

endpackage

//--- hw/dsp_types_pkg.sv
// sample, dac word and accumulation word types of the readout DSP
// imported by the datapath modules and the testbench

package dsp_types_pkg;

	import dsp_cfg_pkg::*;

	// adc word, lane 0 in the low bits
	typedef logic [adc_lanes-1:0][lane_w-1:0] adc_word_t;

	// dac word, same lane order
	typedef logic [dac_lanes-1:0][lane_w-1:0] dac_word_t;

	// readout side view
	// accx in the upper half, accy in the lower half
	typedef struct packed {
		logic [acc_half_w-1:0] accx;
		logic [acc_half_w-1:0] accy;
	} acc_split_t;

	// one accumulation buffer word
	// raw is what the buffer stores, split is how readout fills it
	typedef union packed {
		logic [2*acc_half_w-1:0] raw;
		acc_split_t split;
	} acc_word_t;

endpackage

//--- hw/shot_sequencer.sv
// runs a multi-shot experiment on the processor cores
// a start strobe releases the cores once per shot until nshot shots
// are done, nshot of zero repeats forever

`timescale 1ns/1ps

module shot_sequencer import dsp_cfg_pkg::*; (
	input logic dspif,
	input logic arst_n,
	input logic stb_start,
	input logic [shot_w-1:0] nshot,
	input logic [nproc-1:0] core_procdone,
	input logic [nproc-1:0] core_nobusy,
	output logic core_reset,
	output logic [shot_w-1:0] shotcnt,
	output logic lastshotdone,
	output logic procdone
);

	// gray-like codes, neighbours differ in one bit
	typedef enum logic [2:0] {
		st_idle = 3'b000,
		st_start = 3'b001,
		st_procrun = 3'b011,
		st_elembusy = 3'b010,
		st_moreshot = 3'b110,
		st_shotadd = 3'b111,
		st_done = 3'b101
	} state_t;

	state_t state;
	state_t next_state;

	// registered reductions of the core levels
	logic procdone_all;
	logic nobusy_all;
	// shot index, its increment and the pipelined decision
	logic [shot_w-1:0] shot_idx;
	logic [shot_w-1:0] next_idx;
	logic [shot_w-1:0] nshot_r;
	logic more_shots;
	// high through the start state
	logic shot_start;

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle: if (stb_start) next_state = st_start;
			st_start: next_state = st_procrun;
			// wait for every core to finish its program
			st_procrun: if (procdone_all) next_state = st_elembusy;
			// then for every element to drain
			st_elembusy: if (nobusy_all) next_state = st_moreshot;
			st_moreshot: next_state = more_shots ? st_shotadd : st_done;
			st_shotadd: next_state = st_start;
			st_done: next_state = st_idle;
			default: next_state = st_idle;
		endcase
	end

	// decision is ready long before moreshot, shot_idx is stable for a shot
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			procdone_all <= 1'b0;
			nobusy_all <= 1'b0;
			next_idx <= '0;
			more_shots <= 1'b0;
		end else begin
			procdone_all <= &core_procdone;
			nobusy_all <= &core_nobusy;
			next_idx <= shot_idx + 1'b1;
			more_shots <= (next_idx != nshot_r) || (nshot_r == '0);
		end
	end

	// outputs follow the state being entered
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			core_reset <= 1'b1;
			lastshotdone <= 1'b0;
			shot_start <= 1'b0;
			shot_idx <= '0;
			shotcnt <= '0;
			nshot_r <= '0;
		end else begin
			core_reset <= 1'b1;
			lastshotdone <= 1'b0;
			shot_start <= 1'b0;
			case (next_state)
				st_idle: begin
					shot_idx <= '0;
					nshot_r <= nshot;
				end
				st_start: begin
					core_reset <= 1'b0;
					shot_start <= 1'b1;
				end
				st_procrun: core_reset <= 1'b0;
				// report the shot just finished
				st_shotadd: begin
					shotcnt <= shot_idx;
					shot_idx <= next_idx;
				end
				st_done: begin
					lastshotdone <= 1'b1;
					shot_idx <= '0;
				end
				default: ;
			endcase
		end
	end

	// sticky until the next shot starts
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			procdone <= 1'b0;
		end else if (procdone_all) begin
			procdone <= 1'b1;
		end else if (shot_start) begin
			procdone <= 1'b0;
		end
	end

endmodule

//--- hw/baseband_select.sv
// picks the two readout basebands
// each comes from its own registered adc word or its own undersampled
// dac word, two cycles after the inputs

`timescale 1ns/1ps

module baseband_select import dsp_cfg_pkg::*, dsp_types_pkg::*; (
	input logic dspif,
	input logic arst_n,
	input adc_word_t adc [nadc],
	input dac_word_t dac [ndac],
	input logic [bb_sel_w-1:0] bb_sel [nadc],
	output adc_word_t bb [nadc]
);

	// first stage
	adc_word_t adc_r [nadc];
	adc_word_t dac_us [ndac];

	always_ff @(posedge dspif) begin
		for (int i = 0; i < nadc; i++) begin
			adc_r[i] <= adc[i];
		end
		// lanes 0, 4, 8, 12 of each dac word
		for (int i = 0; i < ndac; i++) begin
			for (int j = 0; j < adc_lanes; j++) begin
				dac_us[i][j] <= dac[i][j*undersample_step];
			end
		end
	end

	// second stage, one mux per baseband
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < nadc; k++) begin
				bb[k] <= '0;
			end
		end else begin
			for (int k = 0; k < nadc; k++) begin
				case (bb_sel[k])
					0: bb[k] <= adc_r[k];
					1: bb[k] <= dac_us[k];
					// unused codes keep the last baseband
					default: bb[k] <= bb[k];
				endcase
			end
		end
	end

endmodule

//--- hw/readout_accum.sv
// one readout channel
// mixes the baseband with the lo pair over a gate window, writes one
// scaled accumulation word per window and steps the buffer pointer

`timescale 1ns/1ps

module readout_accum import dsp_cfg_pkg::*, dsp_types_pkg::*; (
	input logic dspif,
	input logic arst_n,
	input adc_word_t bb,
	input adc_word_t lo_x,
	input adc_word_t lo_y,
	input logic gate,
	input logic [shift_w-1:0] shift,
	input logic resetacc,
	output acc_word_t acc_data,
	output logic [acc_addr_w-1:0] acc_addr,
	output logic acc_we
);

	// lane products need 2*lane_w, plus headroom for the lane sum
	logic signed [2*lane_w+1:0] mix_x;
	logic signed [2*lane_w+1:0] mix_y;
	logic signed [2*lane_w+1:0] mix_x_r;
	logic signed [2*lane_w+1:0] mix_y_r;
	logic gate_r;
	logic gate_d;
	// full width accumulators
	logic signed [2*acc_half_w-1:0] acc_x;
	logic signed [2*acc_half_w-1:0] acc_y;
	logic signed [2*acc_half_w-1:0] scaled_x;
	logic signed [2*acc_half_w-1:0] scaled_y;
	logic resetacc_r;
	logic window_end;

	// dot product of baseband with each lo
	always_comb begin
		mix_x = '0;
		mix_y = '0;
		for (int i = 0; i < adc_lanes; i++) begin
			mix_x = mix_x + $signed(bb[i]) * $signed(lo_x[i]);
			mix_y = mix_y + $signed(bb[i]) * $signed(lo_y[i]);
		end
	end

	// stage 1
	always_ff @(posedge dspif) begin
		mix_x_r <= mix_x;
		mix_y_r <= mix_y;
	end

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			gate_r <= 1'b0;
			gate_d <= 1'b0;
			resetacc_r <= 1'b0;
		end else begin
			gate_r <= gate;
			gate_d <= gate_r;
			resetacc_r <= resetacc;
		end
	end

	// first low cycle of the registered gate
	assign window_end = gate_d & ~gate_r;

	assign scaled_x = acc_x >>> shift;
	assign scaled_y = acc_y >>> shift;

	// stage 2, accumulate then dump and clear
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			acc_x <= '0;
			acc_y <= '0;
			acc_we <= 1'b0;
		end else begin
			acc_we <= window_end;
			if (gate_r) begin
				acc_x <= acc_x + mix_x_r;
				acc_y <= acc_y + mix_y_r;
			end else if (window_end) begin
				acc_x <= '0;
				acc_y <= '0;
			end
		end
	end

	// truncated to the buffer half width
	always_ff @(posedge dspif) begin
		if (window_end) begin
			acc_data.split.accx <= scaled_x[acc_half_w-1:0];
			acc_data.split.accy <= scaled_y[acc_half_w-1:0];
		end
	end

	// write pointer, locks at the last address
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			acc_addr <= '0;
		end else if (resetacc_r) begin
			acc_addr <= '0;
		end else if (acc_we && !(&acc_addr)) begin
			acc_addr <= acc_addr + 1'b1;
		end
	end

endmodule

//--- hw/dac_slice_sum.sv
// adds a group of drive words lane by lane into one dac word
// each lane saturates to the signed 16-bit range, one cycle latency

`timescale 1ns/1ps

module dac_slice_sum import dsp_cfg_pkg::*, dsp_types_pkg::*; (
	input logic dspif,
	input logic arst_n,
	input dac_word_t drv [ndrv_group],
	output dac_word_t dac
);

	dac_word_t sat_word;

	always_comb begin
		// wide enough for ndrv_group full scale lanes
		logic signed [lane_w+$clog2(ndrv_group):0] lane_sum;
		for (int l = 0; l < dac_lanes; l++) begin
			lane_sum = '0;
			for (int g = 0; g < ndrv_group; g++) begin
				lane_sum = lane_sum + $signed(drv[g][l]);
			end
			// top bits all equal means the sum fits in one lane
			if ((&lane_sum[lane_w+$clog2(ndrv_group):lane_w-1]) ||
				!(|lane_sum[lane_w+$clog2(ndrv_group):lane_w-1])) begin
				sat_word[l] = lane_sum[lane_w-1:0];
			end else if (lane_sum[lane_w+$clog2(ndrv_group)]) begin
				// clip to most negative
				sat_word[l] = {1'b1, {(lane_w-1){1'b0}}};
			end else begin
				// clip to most positive
				sat_word[l] = {1'b0, {(lane_w-1){1'b1}}};
			end
		end
	end

	// dac idles at zero out of reset
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			dac <= '0;
		end else begin
			dac <= sat_word;
		end
	end

endmodule

//--- hw/dsp_top.sv
// readout DSP top level
// shot sequencer for the processor cores, baseband select, four
// mix-and-accumulate channels and the two summed dac outputs

`timescale 1ns/1ps

module dsp_top import dsp_cfg_pkg::*, dsp_types_pkg::*; (
	input logic dspif,
	input logic arst_n,
	input logic stb_start,
	input logic [shot_w-1:0] nshot,
	input logic [nproc-1:0] core_procdone,
	input logic [nproc-1:0] core_nobusy,
	output logic core_reset,
	output logic [shot_w-1:0] shotcnt,
	output logic lastshotdone,
	output logic procdone,
	input adc_word_t adc [nadc],
	input dac_word_t drv [ndac][ndrv_group],
	output dac_word_t dac [ndac],
	input logic [bb_sel_w-1:0] bb_sel [nadc],
	input adc_word_t lo_x [ndlo],
	input adc_word_t lo_y [ndlo],
	input logic [ndlo-1:0] gate,
	input logic [shift_w-1:0] shift,
	input logic resetacc,
	output acc_word_t acc_data [ndlo],
	output logic [acc_addr_w-1:0] acc_addr [ndlo],
	output logic [ndlo-1:0] acc_we
);

	// the two selected basebands
	adc_word_t bb [nadc];

	shot_sequencer u_seq (
		.dspif(dspif),
		.arst_n(arst_n),
		.stb_start(stb_start),
		.nshot(nshot),
		.core_procdone(core_procdone),
		.core_nobusy(core_nobusy),
		.core_reset(core_reset),
		.shotcnt(shotcnt),
		.lastshotdone(lastshotdone),
		.procdone(procdone)
	);

	// dac outputs loop back as a baseband source
	baseband_select u_bbsel (
		.dspif(dspif),
		.arst_n(arst_n),
		.adc(adc),
		.dac(dac),
		.bb_sel(bb_sel),
		.bb(bb)
	);

	// low channels on baseband 0, the rest on baseband 1
	for (genvar i = 0; i < ndlo; i++) begin : g_rdlo
		readout_accum u_acc (
			.dspif(dspif),
			.arst_n(arst_n),
			.bb(bb[(i < ndlo1) ? 0 : 1]),
			.lo_x(lo_x[i]),
			.lo_y(lo_y[i]),
			.gate(gate[i]),
			.shift(shift),
			.resetacc(resetacc),
			.acc_data(acc_data[i]),
			.acc_addr(acc_addr[i]),
			.acc_we(acc_we[i])
		);
	end

	// one summing slice per dac
	for (genvar d = 0; d < ndac; d++) begin : g_dac
		dac_slice_sum u_sum (
			.dspif(dspif),
			.arst_n(arst_n),
			.drv(drv[d]),
			.dac(dac[d])
		);
	end

endmodule

//--- sim/tb_dsp_top.sv
// testbench for the readout DSP top level
// a core model answers the shot sequencer, the stimulus runs shots,
// mix windows and random drive words, concurrent assertions check

`timescale 1ns/1ps

module tb_dsp_top import dsp_cfg_pkg::*, dsp_types_pkg::*; ();

	logic dspif;
	logic arst_n;
	logic stb_start;
	logic [shot_w-1:0] nshot;
	logic [nproc-1:0] core_procdone;
	logic [nproc-1:0] core_nobusy;
	logic core_reset;
	logic [shot_w-1:0] shotcnt;
	logic lastshotdone;
	logic procdone;
	adc_word_t adc [nadc];
	dac_word_t drv [ndac][ndrv_group];
	dac_word_t dac [ndac];
	logic [bb_sel_w-1:0] bb_sel [nadc];
	adc_word_t lo_x [ndlo];
	adc_word_t lo_y [ndlo];
	logic [ndlo-1:0] gate;
	logic [shift_w-1:0] shift;
	logic resetacc;
	acc_word_t acc_data [ndlo];
	logic [acc_addr_w-1:0] acc_addr [ndlo];
	logic [ndlo-1:0] acc_we;

	integer seed;
	// reference state
	int exp_nshot;
	int fall_cnt;
	logic core_reset_q;
	logic [acc_half_w-1:0] exp_accx [ndlo];
	logic [acc_half_w-1:0] exp_accy [ndlo];
	int wr_cnt [ndlo];
	dac_word_t drv_q [ndac][ndrv_group];
	// core model
	int run_cyc;
	logic running;
	int done_at [nproc];
	int busy_at [nproc];

	dsp_top DUT (.*);

	always #2 dspif = ~dspif;

	task automatic stop_with_failure(string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(string name, logic [255:0] expv, logic [255:0] actv);
		stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s expected %0h, got %0h",
			$time, name, expv, actv));
	endtask

	function automatic adc_word_t random_adc();
		adc_word_t w;
		for (int i = 0; i < adc_lanes; i++) w[i] = 16'($random(seed));
		return w;
	endfunction

	function automatic dac_word_t random_dac();
		dac_word_t w;
		for (int i = 0; i < dac_lanes; i++) w[i] = 16'($random(seed));
		return w;
	endfunction

	// lane-wise sum clipped to the signed 16-bit range
	function automatic dac_word_t clipped_sum(dac_word_t a, dac_word_t b);
		dac_word_t r;
		int s;
		for (int l = 0; l < dac_lanes; l++) begin
			s = int'($signed(a[l])) + int'($signed(b[l]));
			if (s > 32767) r[l] = 16'h7fff;
			else if (s < -32768) r[l] = 16'h8000;
			else r[l] = 16'(s);
		end
		return r;
	endfunction

	// dac lanes 0, 4, 8 and 12 as one adc word
	function automatic adc_word_t pick_lanes(dac_word_t w);
		adc_word_t r;
		for (int j = 0; j < adc_lanes; j++) r[j] = w[4*j];
		return r;
	endfunction

	function automatic longint lane_dot(adc_word_t a, adc_word_t b);
		longint s;
		s = 0;
		for (int i = 0; i < adc_lanes; i++) begin
			s += longint'($signed(a[i])) * longint'($signed(b[i]));
		end
		return s;
	endfunction

	// pointer sticks at the last buffer address
	function automatic int capped_addr(int k);
		return (k > 15) ? 15 : k;
	endfunction

	task automatic wait_last_shot(int limit);
		int cyc;
		cyc = 0;
		while (lastshotdone !== 1'b1) begin
			if (cyc >= limit) begin
				stop_with_failure("timeout: lastshotdone never came after the start strobe");
			end else begin
				@(negedge dspif);
				cyc++;
			end
		end
	endtask

	task automatic wait_acc_write(int limit);
		int cyc;
		cyc = 0;
		while (acc_we !== '1) begin
			if (cyc >= limit) begin
				stop_with_failure("timeout: no accumulation write on every channel after the gate");
			end else begin
				@(negedge dspif);
				cyc++;
			end
		end
	endtask

	task automatic run_shots(int n);
		@(posedge dspif);
		nshot <= n;
		exp_nshot <= n;
		// nshot is picked up while idle
		@(posedge dspif);
		stb_start <= 1'b1;
		@(posedge dspif);
		stb_start <= 1'b0;
		wait_last_shot(100 * n);
		repeat (3) @(posedge dspif);
	endtask

	task automatic gate_window(int n);
		@(posedge dspif);
		gate <= '1;
		repeat (n) @(posedge dspif);
		gate <= '0;
		wait_acc_write(20);
		repeat (2) @(posedge dspif);
	endtask

	// new random samples, then the expected words, then one window
	task automatic mix_window(int sel, int sh, int n);
		adc_word_t src;
		longint acc;
		int g;
		@(posedge dspif);
		for (int k = 0; k < nadc; k++) begin
			adc[k] <= random_adc();
			bb_sel[k] <= bb_sel_w'(sel);
		end
		for (int d = 0; d < ndac; d++) begin
			for (int j = 0; j < ndrv_group; j++) drv[d][j] <= random_dac();
		end
		for (int c = 0; c < ndlo; c++) begin
			lo_x[c] <= random_adc();
			lo_y[c] <= random_adc();
		end
		shift <= shift_w'(sh);
		@(posedge dspif);
		for (int c = 0; c < ndlo; c++) begin
			g = (c < ndlo1) ? 0 : 1;
			src = (sel == 0) ? adc[g] : pick_lanes(clipped_sum(drv[g][0], drv[g][1]));
			acc = (longint'(n) * lane_dot(src, lo_x[c])) >>> sh;
			exp_accx[c] = acc[acc_half_w-1:0];
			acc = (longint'(n) * lane_dot(src, lo_y[c])) >>> sh;
			exp_accy[c] = acc[acc_half_w-1:0];
		end
		// dac, baseband and mixer stages settle
		repeat (4) @(posedge dspif);
		gate_window(n);
	endtask

	// processor cores, done after 2 to 9 cycles, idle a bit later
	always @(posedge dspif) begin
		if (!arst_n) begin
			running = 1'b0;
			run_cyc = 0;
			core_procdone <= '0;
			core_nobusy <= '0;
		end else begin
			if (!core_reset && !running) begin
				running = 1'b1;
				run_cyc = 0;
				for (int i = 0; i < nproc; i++) begin
					done_at[i] = 2 + $unsigned($random(seed)) % 8;
					busy_at[i] = done_at[i] + 1 + $unsigned($random(seed)) % 3;
				end
			end else if (core_reset && running) begin
				running = 1'b0;
			end
			run_cyc++;
			for (int i = 0; i < nproc; i++) begin
				core_procdone[i] <= running && (run_cyc >= done_at[i]);
				core_nobusy[i] <= run_cyc >= busy_at[i];
			end
		end
	end

	// core reset low periods since the start strobe, writes since resetacc
	always @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			fall_cnt <= 0;
			core_reset_q <= 1'b1;
			for (int c = 0; c < ndlo; c++) wr_cnt[c] <= 0;
		end else begin
			core_reset_q <= core_reset;
			if (stb_start) fall_cnt <= 0;
			else if (core_reset_q && !core_reset) fall_cnt <= fall_cnt + 1;
			for (int c = 0; c < ndlo; c++) begin
				if (resetacc) wr_cnt[c] <= 0;
				else if (acc_we[c]) wr_cnt[c] <= wr_cnt[c] + 1;
			end
		end
	end

	always @(posedge dspif) drv_q <= drv;

	// reset values, looked at between clock edges
	assert property (@(negedge dspif) !arst_n |-> {core_reset, lastshotdone, procdone} == 3'b100)
	else report_mismatch("{core_reset, lastshotdone, procdone}", 3'b100,
		$sampled({core_reset, lastshotdone, procdone}));
	assert property (@(negedge dspif) !arst_n |-> acc_we == '0)
	else report_mismatch("acc_we", 0, $sampled(acc_we));

	assert property (@(posedge dspif) disable iff (!arst_n) lastshotdone |-> fall_cnt == exp_nshot)
	else report_mismatch("core_reset low periods", exp_nshot, $sampled(fall_cnt));
	assert property (@(posedge dspif) disable iff (!arst_n) lastshotdone |=> !lastshotdone)
	else report_mismatch("lastshotdone", 0, 1);
	assert property (@(posedge dspif) disable iff (!arst_n)
		$fell(lastshotdone) && exp_nshot >= 2 |-> shotcnt == shot_w'(exp_nshot - 2))
	else report_mismatch("shotcnt", exp_nshot - 2, $sampled(shotcnt));

	// procdone follows the registered core done by one cycle
	assert property (@(posedge dspif) disable iff (!arst_n)
		$rose(procdone) |-> $past(&core_procdone, 2))
	else report_mismatch("&core_procdone two cycles before procdone rose", 1, 0);
	assert property (@(posedge dspif) disable iff (!arst_n) $fell(core_reset) |=> !procdone)
	else report_mismatch("procdone after core_reset fell", 0, 1);

	// buffer word as stored, accx in the upper half and accy below
	for (genvar c = 0; c < ndlo; c++) begin : g_acc_chk
		assert property (@(posedge dspif) disable iff (!arst_n)
			acc_we[c] |-> acc_data[c].raw[2*acc_half_w-1:acc_half_w] == exp_accx[c])
		else report_mismatch($sformatf("acc_data[%0d].accx", c), exp_accx[c],
			$sampled(acc_data[c].raw[2*acc_half_w-1:acc_half_w]));
		assert property (@(posedge dspif) disable iff (!arst_n)
			acc_we[c] |-> acc_data[c].raw[acc_half_w-1:0] == exp_accy[c])
		else report_mismatch($sformatf("acc_data[%0d].accy", c), exp_accy[c],
			$sampled(acc_data[c].raw[acc_half_w-1:0]));
		assert property (@(posedge dspif) disable iff (!arst_n)
			acc_we[c] |-> acc_addr[c] == capped_addr(wr_cnt[c]))
		else report_mismatch($sformatf("acc_addr[%0d]", c), capped_addr($sampled(wr_cnt[c])),
			$sampled(acc_addr[c]));
	end

	for (genvar d = 0; d < ndac; d++) begin : g_dac_chk
		assert property (@(posedge dspif) disable iff (!arst_n)
			dac[d] == clipped_sum(drv_q[d][0], drv_q[d][1]))
		else report_mismatch($sformatf("dac[%0d]", d), clipped_sum(drv_q[d][0], drv_q[d][1]),
			$sampled(dac[d]));
	end

	initial begin
		seed = 32'he66a;
		dspif = 1'b0;
		arst_n = 1'b0;
		stb_start = 1'b0;
		nshot = '0;
		core_procdone = '0;
		core_nobusy = '0;
		gate = '0;
		shift = '0;
		resetacc = 1'b0;
		exp_nshot = 0;
		for (int k = 0; k < nadc; k++) begin
			adc[k] = '0;
			bb_sel[k] = '0;
		end
		for (int d = 0; d < ndac; d++) begin
			for (int j = 0; j < ndrv_group; j++) drv[d][j] = '0;
		end
		for (int c = 0; c < ndlo; c++) begin
			lo_x[c] = '0;
			lo_y[c] = '0;
			exp_accx[c] = '0;
			exp_accy[c] = '0;
		end
		repeat (2) @(posedge dspif);
		arst_n <= 1'b1;
		repeat (3) @(posedge dspif);
		run_shots(1);
		run_shots(3);
		run_shots(5);
		// adc baseband, dac baseband, then a scaled result
		mix_window(0, 0, 6);
		mix_window(1, 0, 9);
		mix_window(1, 11, 7);
		@(posedge dspif);
		resetacc <= 1'b1;
		@(posedge dspif);
		resetacc <= 1'b0;
		repeat (2) @(posedge dspif);
		// pointer walks up and locks at the last address
		repeat (20) gate_window(7);
		repeat (40) begin
			@(posedge dspif);
			for (int d = 0; d < ndac; d++) begin
				for (int j = 0; j < ndrv_group; j++) drv[d][j] <= random_dac();
			end
		end
		repeat (3) @(posedge dspif);
		$display("All tests passed");
		$finish;
	end

endmodule

//--- dsp_top.f
hw/dsp_cfg_pkg.sv
hw/dsp_types_pkg.sv
hw/shot_sequencer.sv
hw/baseband_select.sv
hw/readout_accum.sv
hw/dac_slice_sum.sv
hw/dsp_top.sv
sim/tb_dsp_top.sv
